// File: decoding_graph.f
+incdir+test
rtl/decoder_pkg.sv
rtl/syndrome_loader.sv
rtl/processing_unit.sv
rtl/neighbor_link.sv
rtl/cluster_parity_unit.sv
rtl/decoding_graph.sv
test/decoding_graph_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the decoding graph testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module decoding_graph_tb -f decoding_graph.f -o decoding_graph_sim

output=$(./obj_dir/decoding_graph_sim)
echo "$output"

if echo "$output" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1

// File: test/decoding_graph_ref.svh
`ifndef DECODING_GRAPH_REF_SVH
`define DECODING_GRAPH_REF_SVH

// Every node starts as a cluster of its own
function automatic void own_roots(output decoder_pkg::address_t roots [decoder_pkg::PU_COUNT]);
    for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
        roots[i] = decoder_pkg::address_t'(i);
    end
endfunction

// Odd when a cluster holds an odd defect count and reaches no grown boundary
function automatic logic [decoder_pkg::PU_COUNT-1:0] cluster_odd(
    input logic [decoder_pkg::PU_COUNT-1:0] defects,
    input decoder_pkg::address_t            roots [decoder_pkg::PU_COUNT],
    input logic [decoder_pkg::PU_COUNT-1:0] touch
);
    logic [decoder_pkg::PU_COUNT-1:0] parity_by_root;   // Indexed by root address
    logic [decoder_pkg::PU_COUNT-1:0] touch_by_root;
    logic [decoder_pkg::PU_COUNT-1:0] odd;

    parity_by_root = '0;
    touch_by_root  = '0;
    for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
        parity_by_root[roots[i]] = parity_by_root[roots[i]] ^ defects[i];
        touch_by_root[roots[i]]  = touch_by_root[roots[i]] | touch[i];
    end
    for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
        odd[i] = parity_by_root[roots[i]] & ~touch_by_root[roots[i]];
    end
    return odd;
endfunction

// Runs a number of grow phases, each followed by a merge to convergence
function automatic void ref_decode(
    input  logic [decoder_pkg::PU_COUNT-1:0] defects,
    input  int                               phases,
    output decoder_pkg::address_t            roots [decoder_pkg::PU_COUNT],
    output logic [decoder_pkg::PU_COUNT-1:0] odd
);
    int                               ew_w [decoder_pkg::GRID_WIDTH_U][decoder_pkg::GRID_WIDTH_X+1];
    int                               ud_w [decoder_pkg::GRID_WIDTH_U+1][decoder_pkg::GRID_WIDTH_X];
    logic [decoder_pkg::PU_COUNT-1:0] touch;
    int                               edge_a [$];
    int                               edge_b [$];
    int                               ends;
    int                               ia;
    int                               ib;
    decoder_pkg::address_t            low;
    bit                               changed;

    own_roots(roots);
    foreach (ew_w[u, e]) ew_w[u][e] = 0;   // Edge e lies west of column e
    foreach (ud_w[k, x]) ud_w[k][x] = 0;   // Edge k lies below round k
    touch = '0;
    odd   = cluster_odd(defects, roots, touch);

    for (int p = 0; p < phases; p++) begin
        for (int u = 0; u < decoder_pkg::GRID_WIDTH_U; u++) begin
            for (int e = 0; e <= decoder_pkg::GRID_WIDTH_X; e++) begin
                ends = 0;
                if (e > 0) ends += int'(odd[u*decoder_pkg::GRID_WIDTH_X + e - 1]);
                if (e < decoder_pkg::GRID_WIDTH_X) ends += int'(odd[u*decoder_pkg::GRID_WIDTH_X + e]);
                ew_w[u][e] = (ew_w[u][e] + ends > decoder_pkg::MAX_WEIGHT)
                           ? decoder_pkg::MAX_WEIGHT : ew_w[u][e] + ends;
            end
        end
        for (int k = 1; k < decoder_pkg::GRID_WIDTH_U; k++) begin
            for (int x = 0; x < decoder_pkg::GRID_WIDTH_X; x++) begin
                ends = int'(odd[(k-1)*decoder_pkg::GRID_WIDTH_X + x])
                     + int'(odd[k*decoder_pkg::GRID_WIDTH_X + x]);
                ud_w[k][x] = (ud_w[k][x] + ends > decoder_pkg::MAX_WEIGHT)
                           ? decoder_pkg::MAX_WEIGHT : ud_w[k][x] + ends;
            end
        end

        // Node pairs joined by a fully grown inner edge
        edge_a.delete();
        edge_b.delete();
        for (int u = 0; u < decoder_pkg::GRID_WIDTH_U; u++) begin
            for (int e = 1; e < decoder_pkg::GRID_WIDTH_X; e++) begin
                if (ew_w[u][e] == decoder_pkg::MAX_WEIGHT) begin
                    edge_a.push_back(u*decoder_pkg::GRID_WIDTH_X + e - 1);
                    edge_b.push_back(u*decoder_pkg::GRID_WIDTH_X + e);
                end
            end
        end
        for (int k = 1; k < decoder_pkg::GRID_WIDTH_U; k++) begin
            for (int x = 0; x < decoder_pkg::GRID_WIDTH_X; x++) begin
                if (ud_w[k][x] == decoder_pkg::MAX_WEIGHT) begin
                    edge_a.push_back((k-1)*decoder_pkg::GRID_WIDTH_X + x);
                    edge_b.push_back(k*decoder_pkg::GRID_WIDTH_X + x);
                end
            end
        end

        // Spread the smallest root until every component agrees
        do begin
            changed = 1'b0;
            foreach (edge_a[n]) begin
                ia = edge_a[n];
                ib = edge_b[n];
                if (roots[ia] != roots[ib]) begin
                    low       = (roots[ia] < roots[ib]) ? roots[ia] : roots[ib];
                    roots[ia] = low;
                    roots[ib] = low;
                    changed   = 1'b1;
                end
            end
        end while (changed);

        for (int u = 0; u < decoder_pkg::GRID_WIDTH_U; u++) begin
            touch[u*decoder_pkg::GRID_WIDTH_X] = (ew_w[u][0] == decoder_pkg::MAX_WEIGHT);
            touch[u*decoder_pkg::GRID_WIDTH_X + decoder_pkg::GRID_WIDTH_X - 1] =
                (ew_w[u][decoder_pkg::GRID_WIDTH_X] == decoder_pkg::MAX_WEIGHT);
        end
        odd = cluster_odd(defects, roots, touch);
    end
endfunction

`endif

// File: test/decoding_graph_tb.sv
`default_nettype none

module decoding_graph_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RANDOM_SEED  = 34132;
    localparam int RANDOM_TESTS = 20;
    localparam int MAX_PHASES   = 3;
    // A random test takes about 4 load + 3 * (2 grow + 15 merge) cycles
    // and all 24 tests stay near 1300 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic                                 clk          = 1'b0;
    logic                                 arst_n       = 1'b0;
    logic [decoder_pkg::GRID_WIDTH_X-1:0] measurements = '0;
    decoder_pkg::stage_t                  stage        = decoder_pkg::STAGE_IDLE;
    logic [decoder_pkg::PU_COUNT-1:0]     odd_clusters;
    decoder_pkg::address_t                roots [decoder_pkg::PU_COUNT];
    logic [decoder_pkg::PU_COUNT-1:0]     busy;

    decoder_pkg::address_t                exp_roots [decoder_pkg::PU_COUNT];
    logic [decoder_pkg::PU_COUNT-1:0]     exp_odd;
    string                                check_name;
    bit                                   check_req   = 1'b0;   // Hands a check to the comparer
    int                                   check_count = 0;
    int                                   error_count = 0;
    int                                   test_count  = 0;
    int                                   cycle_count = 0;

    `include "decoding_graph_ref.svh"

    decoding_graph UUT (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .measurements_i (measurements),
        .global_stage_i (stage),
        .odd_clusters_o (odd_clusters),
        .roots_o        (roots),
        .busy_o         (busy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare_roots(
        input string                 name,
        input decoder_pkg::address_t expected [decoder_pkg::PU_COUNT],
        input decoder_pkg::address_t actual [decoder_pkg::PU_COUNT]
    );
        for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
            check_count++;
            if (actual[i] !== expected[i]) begin
                error_count++;
                $display("MISMATCH %s root[%0d] expected %0d actual %0d",
                         name, i, expected[i], actual[i]);
            end
        end
    endtask

    task automatic compare_bits(
        input string                            name,
        input logic [decoder_pkg::PU_COUNT-1:0] expected,
        input logic [decoder_pkg::PU_COUNT-1:0] actual
    );
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s expected %b actual %b", name, expected, actual);
        end
    endtask

    // Busy stays low while the graph is idle
    always begin
        wait (check_req);
        compare_roots(check_name, exp_roots, roots);
        compare_bits({check_name, " odd"}, exp_odd, odd_clusters);
        compare_bits({check_name, " busy"}, '0, busy);
        check_req = 1'b0;
    end

    task automatic check_outputs(
        input string                            name,
        input decoder_pkg::address_t            roots_exp [decoder_pkg::PU_COUNT],
        input logic [decoder_pkg::PU_COUNT-1:0] odd_exp
    );
        @(negedge clk);   // Outputs settled
        exp_roots  = roots_exp;
        exp_odd    = odd_exp;
        check_name = name;
        check_req  = 1'b1;
        wait (!check_req);
    endtask

    // First row applied ends up in round 0
    task automatic load_syndrome(input logic [decoder_pkg::PU_COUNT-1:0] defects);
        for (int k = 0; k < decoder_pkg::GRID_WIDTH_U; k++) begin
            @(posedge clk);
            measurements <= defects[k*decoder_pkg::GRID_WIDTH_X +: decoder_pkg::GRID_WIDTH_X];
            stage        <= decoder_pkg::STAGE_LOAD;
        end
        @(posedge clk);
        measurements <= '0;
        stage        <= decoder_pkg::STAGE_IDLE;
    endtask

    task automatic run_grow();
        @(posedge clk);
        stage <= decoder_pkg::STAGE_GROW;
        @(posedge clk);
        stage <= decoder_pkg::STAGE_IDLE;
    endtask

    // Hands back the busy flags seen in the first merge cycle
    task automatic run_merge(output logic [decoder_pkg::PU_COUNT-1:0] first_busy);
        @(posedge clk);
        stage <= decoder_pkg::STAGE_MERGE;
        @(negedge clk);
        first_busy = busy;
        while (busy != '0) begin
            @(negedge clk);
        end
        @(posedge clk);
        stage <= decoder_pkg::STAGE_IDLE;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %-18s ok", name);
        end else begin
            $display("test %-18s %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin : stimulus
        decoder_pkg::address_t            roots_exp [decoder_pkg::PU_COUNT];
        logic [decoder_pkg::PU_COUNT-1:0] odd_exp;
        logic [decoder_pkg::PU_COUNT-1:0] busy_exp;
        logic [decoder_pkg::PU_COUNT-1:0] merge_busy;
        logic [decoder_pkg::PU_COUNT-1:0] defects;
        logic [31:0]                      rnd;
        int                               errors_before;
        int                               node_a;
        int                               node_b;
        string                            name;

        void'($urandom(RANDOM_SEED));
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        errors_before = error_count;
        own_roots(roots_exp);
        check_outputs("reset", roots_exp, '0);
        finish_test("reset", errors_before);

        // Without growth the odd map shows the loaded rows
        errors_before = error_count;
        rnd     = $urandom();
        defects = rnd[decoder_pkg::PU_COUNT-1:0];
        load_syndrome(defects);
        own_roots(roots_exp);
        check_outputs("load", roots_exp, defects);
        finish_test("load", errors_before);

        errors_before = error_count;
        node_a  = decoder_pkg::GRID_WIDTH_X + 1;   // Round 1, columns 1 and 2
        node_b  = node_a + 1;
        defects = '0;
        defects[node_a] = 1'b1;
        defects[node_b] = 1'b1;
        load_syndrome(defects);
        run_grow();
        run_merge(merge_busy);
        busy_exp         = '0;
        busy_exp[node_b] = 1'b1;                   // Only the larger address sees a smaller root
        compare_bits("pair_merge first busy", busy_exp, merge_busy);
        own_roots(roots_exp);
        roots_exp[node_b] = decoder_pkg::address_t'(node_a);
        check_outputs("pair_merge", roots_exp, '0);
        finish_test("pair_merge", errors_before);

        errors_before = error_count;
        node_a  = decoder_pkg::GRID_WIDTH_X;       // Round 1, column 0
        defects = '0;
        defects[node_a] = 1'b1;
        load_syndrome(defects);
        run_grow();
        run_merge(merge_busy);
        own_roots(roots_exp);
        check_outputs("boundary grow 1", roots_exp, defects);
        run_grow();
        run_merge(merge_busy);
        ref_decode(defects, 2, roots_exp, odd_exp);
        check_outputs("boundary grow 2", roots_exp, '0);
        finish_test("boundary", errors_before);

        for (int t = 0; t < RANDOM_TESTS; t++) begin
            errors_before = error_count;
            rnd     = $urandom() & $urandom();     // Sparse syndrome
            defects = rnd[decoder_pkg::PU_COUNT-1:0];
            name    = $sformatf("random_%02d", t);
            load_syndrome(defects);
            for (int p = 1; p <= MAX_PHASES; p++) begin
                run_grow();
                run_merge(merge_busy);
                ref_decode(defects, p, roots_exp, odd_exp);
                check_outputs($sformatf("%s phase %0d", name, p), roots_exp, odd_exp);
                if (odd_exp == '0) break;
            end
            finish_test(name, errors_before);
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/decoding_graph.sv
`default_nettype none

module decoding_graph (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  logic [decoder_pkg::GRID_WIDTH_X-1:0] measurements_i,
    input  decoder_pkg::stage_t                  global_stage_i,
    output logic [decoder_pkg::PU_COUNT-1:0]     odd_clusters_o,
    output decoder_pkg::address_t                roots_o [decoder_pkg::PU_COUNT],
    output logic [decoder_pkg::PU_COUNT-1:0]     busy_o
);

    logic [decoder_pkg::PU_COUNT-1:0] defects;
    logic [decoder_pkg::PU_COUNT-1:0] odd;
    wire  [decoder_pkg::PU_COUNT-1:0] boundary_touch;
    wire  [decoder_pkg::PU_COUNT-1:0] busy;
    wire  decoder_pkg::address_t      roots [decoder_pkg::PU_COUNT];

    // Edge e of a round sits west of column e, edges 0 and X are boundaries
    wire ew_grown [decoder_pkg::GRID_WIDTH_U][decoder_pkg::GRID_WIDTH_X+1];
    // Edge k of a column sits below round k, edges 0 and U are never grown
    wire ud_grown [decoder_pkg::GRID_WIDTH_U+1][decoder_pkg::GRID_WIDTH_X];

    genvar u;
    genvar x;
    genvar e;

    syndrome_loader u_loader (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .global_stage_i (global_stage_i),
        .measurements_i (measurements_i),
        .defects_o      (defects)
    );

    generate
        for (u = 0; u < decoder_pkg::GRID_WIDTH_U; u++) begin : g_pu_round
            for (x = 0; x < decoder_pkg::GRID_WIDTH_X; x++) begin : g_pu_col
                decoder_pkg::address_t                slot_roots [decoder_pkg::NEIGHBOR_COUNT];
                logic [decoder_pkg::NEIGHBOR_COUNT-1:0] slot_grown;

                // Slots without a partner node see their own root
                always_comb begin
                    slot_roots[decoder_pkg::NEIGHBOR_IDX_WEST] =
                        roots[(x > 0) ? u*decoder_pkg::GRID_WIDTH_X + x - 1
                                      : u*decoder_pkg::GRID_WIDTH_X + x];
                    slot_roots[decoder_pkg::NEIGHBOR_IDX_EAST] =
                        roots[(x < decoder_pkg::GRID_WIDTH_X - 1)
                              ? u*decoder_pkg::GRID_WIDTH_X + x + 1
                              : u*decoder_pkg::GRID_WIDTH_X + x];
                    slot_roots[decoder_pkg::NEIGHBOR_IDX_DOWN] =
                        roots[(u > 0) ? (u-1)*decoder_pkg::GRID_WIDTH_X + x
                                      : u*decoder_pkg::GRID_WIDTH_X + x];
                    slot_roots[decoder_pkg::NEIGHBOR_IDX_UP] =
                        roots[(u < decoder_pkg::GRID_WIDTH_U - 1)
                              ? (u+1)*decoder_pkg::GRID_WIDTH_X + x
                              : u*decoder_pkg::GRID_WIDTH_X + x];
                    slot_grown[decoder_pkg::NEIGHBOR_IDX_WEST] = ew_grown[u][x];
                    slot_grown[decoder_pkg::NEIGHBOR_IDX_EAST] = ew_grown[u][x+1];
                    slot_grown[decoder_pkg::NEIGHBOR_IDX_DOWN] = ud_grown[u][x];
                    slot_grown[decoder_pkg::NEIGHBOR_IDX_UP]   = ud_grown[u+1][x];
                end

                processing_unit #(
                    .ADDRESS (decoder_pkg::address_t'(u*decoder_pkg::GRID_WIDTH_X + x))
                ) u_pu (
                    .clk                    (clk),
                    .arst_n_i               (arst_n_i),
                    .global_stage_i         (global_stage_i),
                    .neighbor_roots_i       (slot_roots),
                    .neighbor_fully_grown_i (slot_grown),
                    .root_o                 (roots[u*decoder_pkg::GRID_WIDTH_X + x]),
                    .busy_o                 (busy[u*decoder_pkg::GRID_WIDTH_X + x])
                );

                // Only the outer columns own a boundary edge
                assign boundary_touch[u*decoder_pkg::GRID_WIDTH_X + x] =
                    ((x == 0) && ew_grown[u][x])
                    || ((x == decoder_pkg::GRID_WIDTH_X - 1) && ew_grown[u][x+1]);
            end
        end

        for (u = 0; u < decoder_pkg::GRID_WIDTH_U; u++) begin : g_ew_round
            for (e = 0; e <= decoder_pkg::GRID_WIDTH_X; e++) begin : g_ew_edge
                logic b_odd;

                if ((e > 0) && (e < decoder_pkg::GRID_WIDTH_X)) begin : g_inner
                    assign b_odd = odd[u*decoder_pkg::GRID_WIDTH_X + e];
                end else begin : g_boundary
                    assign b_odd = 1'b0;            // Boundary edge, single endpoint
                end

                neighbor_link u_link (
                    .clk            (clk),
                    .arst_n_i       (arst_n_i),
                    .global_stage_i (global_stage_i),
                    .a_odd_i        (odd[u*decoder_pkg::GRID_WIDTH_X + ((e > 0) ? e - 1 : 0)]),
                    .b_odd_i        (b_odd),
                    .fully_grown_o  (ew_grown[u][e])
                );
            end
        end

        for (u = 0; u <= decoder_pkg::GRID_WIDTH_U; u++) begin : g_ud_edge
            for (x = 0; x < decoder_pkg::GRID_WIDTH_X; x++) begin : g_ud_col
                if ((u == 0) || (u == decoder_pkg::GRID_WIDTH_U)) begin : g_open
                    assign ud_grown[u][x] = 1'b0;   // No time boundary on the outer rounds
                end else begin : g_link
                    neighbor_link u_link (
                        .clk            (clk),
                        .arst_n_i       (arst_n_i),
                        .global_stage_i (global_stage_i),
                        .a_odd_i        (odd[(u-1)*decoder_pkg::GRID_WIDTH_X + x]),
                        .b_odd_i        (odd[u*decoder_pkg::GRID_WIDTH_X + x]),
                        .fully_grown_o  (ud_grown[u][x])
                    );
                end
            end
        end
    endgenerate

    cluster_parity_unit u_parity (
        .defects_i        (defects),
        .roots_i          (roots),
        .boundary_touch_i (boundary_touch),
        .odd_o            (odd)
    );

    assign odd_clusters_o = odd;
    assign roots_o        = roots;
    assign busy_o         = busy;

endmodule

`default_nettype wire

// File: rtl/cluster_parity_unit.sv
`default_nettype none

module cluster_parity_unit (
    input  logic [decoder_pkg::PU_COUNT-1:0] defects_i,
    input  decoder_pkg::address_t            roots_i [decoder_pkg::PU_COUNT],
    input  logic [decoder_pkg::PU_COUNT-1:0] boundary_touch_i,
    output logic [decoder_pkg::PU_COUNT-1:0] odd_o
);

    logic [decoder_pkg::PU_COUNT-1:0] cluster_parity;
    logic [decoder_pkg::PU_COUNT-1:0] cluster_touch;

    // A cluster is the set of nodes that share one root, so every node
    // scans the whole array and collects the members of its own cluster.
    // All members of a cluster end up with the same flags.
    always_comb begin
        for (int i = 0; i < decoder_pkg::PU_COUNT; i++) begin
            cluster_parity[i] = 1'b0;
            cluster_touch[i]  = 1'b0;
            for (int j = 0; j < decoder_pkg::PU_COUNT; j++) begin
                if (roots_i[j] == roots_i[i]) begin
                    cluster_parity[i] = cluster_parity[i] ^ defects_i[j];
                    cluster_touch[i]  = cluster_touch[i] | boundary_touch_i[j];
                end
            end
        end
    end

    // A grown boundary absorbs any leftover defect
    assign odd_o = cluster_parity & ~cluster_touch;

endmodule

`default_nettype wire

// File: rtl/neighbor_link.sv
`default_nettype none

module neighbor_link (
    input  logic                clk,
    input  logic                arst_n_i,
    input  decoder_pkg::stage_t global_stage_i,
    input  logic                a_odd_i,
    input  logic                b_odd_i,
    output logic                fully_grown_o
);

    localparam int SUM_WIDTH = decoder_pkg::LINK_BIT_WIDTH + 1;

    decoder_pkg::weight_t  weight_q;
    logic [SUM_WIDTH-1:0]  grown_sum;           // One extra bit so two increments never wrap
    decoder_pkg::weight_t  weight_next;

    // Each odd endpoint pushes the link by one unit
    assign grown_sum = {1'b0, weight_q}
                     + SUM_WIDTH'(a_odd_i)
                     + SUM_WIDTH'(b_odd_i);

    always_comb begin
        if (grown_sum >= SUM_WIDTH'(decoder_pkg::MAX_WEIGHT)) begin
            weight_next = decoder_pkg::weight_t'(decoder_pkg::MAX_WEIGHT);   // Saturate
        end else begin
            weight_next = grown_sum[decoder_pkg::LINK_BIT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            weight_q <= '0;
        end else begin
            case (global_stage_i)
                decoder_pkg::STAGE_LOAD: weight_q <= '0;       // Restart growth for a new syndrome
                decoder_pkg::STAGE_GROW: weight_q <= weight_next;
                default:                 weight_q <= weight_q;
            endcase
        end
    end

    assign fully_grown_o = (weight_q == decoder_pkg::weight_t'(decoder_pkg::MAX_WEIGHT));

endmodule

`default_nettype wire

// File: rtl/processing_unit.sv
`default_nettype none

module processing_unit #(
    parameter decoder_pkg::address_t ADDRESS = '0
) (
    input  logic                                   clk,
    input  logic                                   arst_n_i,
    input  decoder_pkg::stage_t                    global_stage_i,
    input  decoder_pkg::address_t                  neighbor_roots_i [decoder_pkg::NEIGHBOR_COUNT],
    input  logic [decoder_pkg::NEIGHBOR_COUNT-1:0] neighbor_fully_grown_i,
    output decoder_pkg::address_t                  root_o,
    output logic                                   busy_o
);

    decoder_pkg::address_t root_q;
    decoder_pkg::address_t min_root;

    // Smallest root reachable over a fully grown link
    always_comb begin
        min_root = root_q;
        for (int s = 0; s < decoder_pkg::NEIGHBOR_COUNT; s++) begin
            if (neighbor_fully_grown_i[s] && (neighbor_roots_i[s] < min_root)) begin
                min_root = neighbor_roots_i[s];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            root_q <= ADDRESS;
        end else begin
            case (global_stage_i)
                decoder_pkg::STAGE_LOAD:  root_q <= ADDRESS;    // New syndrome, own cluster
                decoder_pkg::STAGE_MERGE: root_q <= min_root;
                default:                  root_q <= root_q;
            endcase
        end
    end

    assign root_o = root_q;

    // Still moving while a smaller root is visible
    assign busy_o = (global_stage_i == decoder_pkg::STAGE_MERGE) && (min_root != root_q);

endmodule

`default_nettype wire

// File: rtl/syndrome_loader.sv
`default_nettype none

module syndrome_loader (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  decoder_pkg::stage_t                  global_stage_i,
    input  logic [decoder_pkg::GRID_WIDTH_X-1:0] measurements_i,
    output logic [decoder_pkg::PU_COUNT-1:0]     defects_o
);

    // One register row per round, the newest row sits at the top
    logic [decoder_pkg::GRID_WIDTH_X-1:0] round_q [decoder_pkg::GRID_WIDTH_U];

    genvar k;

    generate
        for (k = 0; k < decoder_pkg::GRID_WIDTH_U; k++) begin : g_round
            logic [decoder_pkg::GRID_WIDTH_X-1:0] row_in;

            if (k == decoder_pkg::GRID_WIDTH_U - 1) begin : g_top
                assign row_in = measurements_i;    // Fresh measurements enter here
            end else begin : g_chain
                assign row_in = round_q[k+1];      // Rows move down one round per load
            end

            always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    round_q[k] <= '0;
                end else if (global_stage_i == decoder_pkg::STAGE_LOAD) begin
                    round_q[k] <= row_in;
                end
            end

            // Flatten into node order, round k covers addresses k*X to k*X+X-1
            assign defects_o[k*decoder_pkg::GRID_WIDTH_X +: decoder_pkg::GRID_WIDTH_X] =
                round_q[k];
        end
    endgenerate

endmodule

`default_nettype wire

// File: rtl/decoder_pkg.sv
`default_nettype none

package decoder_pkg;

    // Grid geometry, one column row per syndrome round
    localparam int GRID_WIDTH_X = 4;                          // Columns per round
    localparam int GRID_WIDTH_U = 3;                          // Rounds held in the array
    localparam int PU_COUNT     = GRID_WIDTH_X * GRID_WIDTH_U;

    // Growth units before a link counts as fully grown
    localparam int MAX_WEIGHT = 2;

    localparam int ADDRESS_WIDTH  = $clog2(PU_COUNT);
    localparam int LINK_BIT_WIDTH = $clog2(MAX_WEIGHT + 1);   // Counter must reach MAX_WEIGHT

    // Neighbor slots of a processing unit
    localparam int NEIGHBOR_COUNT    = 4;
    localparam int NEIGHBOR_IDX_WEST = 0;
    localparam int NEIGHBOR_IDX_EAST = 1;
    localparam int NEIGHBOR_IDX_DOWN = 2;                     // Towards the older round
    localparam int NEIGHBOR_IDX_UP   = 3;                     // Towards the newer round

    // Node address is round * GRID_WIDTH_X + column
    typedef logic [ADDRESS_WIDTH-1:0] address_t;

    typedef logic [LINK_BIT_WIDTH-1:0] weight_t;

    // Stage driven by the outside controller
    typedef enum logic [1:0] {
        STAGE_IDLE  = 2'd0,   // Hold everything
        STAGE_LOAD  = 2'd1,   // Shift in one row, restart clusters
        STAGE_GROW  = 2'd2,   // Grow links around odd clusters
        STAGE_MERGE = 2'd3    // Spread the smallest root
    } stage_t;

endpackage

`default_nettype wire
